// ==== common/cce_pkg.sv ====
package cce_pkg;

  // Address and datapath sizes
  localparam int paddr_width = 16;
  localparam int gpr_width = 16;

  // General purpose register file
  localparam int num_gpr = 4;
  localparam int gpr_sel_width = $clog2(num_gpr);

  // Microcode store
  localparam int pc_width = 8;
  localparam int ucode_depth = 2 ** pc_width;

  // Memory command type carried on the command channel
  typedef enum logic [0:0] {
    e_mem_rd = 1'b0,
    e_mem_wr = 1'b1
  } cce_mem_op_e;

endpackage

// ==== common/cce_inst_pkg.sv ====
package cce_inst_pkg;

  localparam int inst_width = 26;

  // Microcode opcodes, unused codes decode as nop
  typedef enum logic [3:0] {
    e_nop   = 4'd0,
    e_movi  = 4'd1,
    e_add   = 4'd2,
    e_sub   = 4'd3,
    e_addi  = 4'd4,
    e_beq   = 4'd5,
    e_bne   = 4'd6,
    e_jmp   = 4'd7,
    e_popq  = 4'd8,
    e_pushq = 4'd9
  } cce_opcode_e;

  // Instruction word, op in the top bits
  typedef struct packed {
    cce_opcode_e                        op;
    logic [cce_pkg::gpr_sel_width-1:0] rd;
    logic [cce_pkg::gpr_sel_width-1:0] ra;
    logic [cce_pkg::gpr_sel_width-1:0] rb;
    // Branch targets use the low pc_width bits
    logic [cce_pkg::gpr_width-1:0]     imm;
  } cce_inst_s;

endpackage

// ==== common/cce_ifs.sv ====
// Fetch stage to decode/execute stage
interface cce_fetch_if;

  // PC of the word currently on inst
  logic [cce_pkg::pc_width-1:0] pc;
  cce_inst_pkg::cce_inst_s      inst;
  logic                         inst_v;

  // Back from execute
  logic                         stall;
  logic                         redirect;
  logic [cce_pkg::pc_width-1:0] redirect_pc;

  modport fetch (
    output pc, inst, inst_v,
    input  stall, redirect, redirect_pc
  );

  modport exec (
    input  pc, inst, inst_v,
    output stall, redirect, redirect_pc
  );

endinterface

// Execute to memory command output register, valid/ready
interface cce_cmd_if;

  logic                            v;
  logic [cce_pkg::paddr_width-1:0] addr;
  cce_pkg::cce_mem_op_e            op;
  logic                            ready;

  modport source (
    output v, addr, op,
    input  ready
  );

  modport sink (
    input  v, addr, op,
    output ready
  );

endinterface

// ==== design/cce_req_in.sv ====
module cce_req_in (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic [cce_pkg::paddr_width-1:0] lce_req_addr_i,
  input  logic                            lce_req_v_i,
  output logic                            lce_req_yumi_o,
  output logic                            req_v_o,
  output logic [cce_pkg::paddr_width-1:0] req_addr_o,
  input  logic                            req_pop_i
);

  logic                            full_r;
  logic [cce_pkg::paddr_width-1:0] addr_r;

  // Accept only into an empty slot, so a pop never races a fill
  assign lce_req_yumi_o = lce_req_v_i && !full_r;
  assign req_v_o = full_r;
  assign req_addr_o = addr_r;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      full_r <= 1'b0;
    end else if (lce_req_yumi_o) begin
      full_r <= 1'b1;
    end else if (req_pop_i) begin
      full_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (lce_req_yumi_o) begin
      addr_r <= lce_req_addr_i;
    end
  end

  // Execute only pops a request that is really buffered
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_pop_i |-> full_r);

endmodule

// ==== design/cce_fetch.sv ====
module cce_fetch (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                cce_mode_i,
  input  logic                                ucode_v_i,
  input  logic                                ucode_w_i,
  input  logic [cce_pkg::pc_width-1:0]        ucode_addr_i,
  input  logic [cce_inst_pkg::inst_width-1:0] ucode_data_i,
  output logic [cce_inst_pkg::inst_width-1:0] ucode_data_o,
  cce_fetch_if.fetch                          fetch_if
);

  logic [cce_inst_pkg::inst_width-1:0] ram [cce_pkg::ucode_depth];
  logic [cce_inst_pkg::inst_width-1:0] ram_q;
  logic [cce_pkg::pc_width-1:0]        ram_addr;
  logic                                ram_we;
  logic                                ram_re;

  // pc_r is the word being read, inst_pc_r the word on ram_q
  logic [cce_pkg::pc_width-1:0]        pc_r;
  logic [cce_pkg::pc_width-1:0]        inst_pc_r;
  logic                                inst_v_r;

  // Programming port owns the RAM while halted
  assign ram_we = !cce_mode_i && ucode_v_i && ucode_w_i;
  assign ram_re = cce_mode_i ? !fetch_if.stall : (ucode_v_i && !ucode_w_i);
  assign ram_addr = cce_mode_i ? pc_r : ucode_addr_i;

  always_ff @(posedge clk_i) begin
    if (ram_we) begin
      ram[ucode_addr_i] <= ucode_data_i;
    end
    if (ram_re) begin
      ram_q <= ram[ram_addr];
    end
  end

  // Sequential fetch, predict not taken
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_r <= '0;
      inst_pc_r <= '0;
      inst_v_r <= 1'b0;
    end else if (!cce_mode_i) begin
      pc_r <= '0;
      inst_pc_r <= '0;
      inst_v_r <= 1'b0;
    end else if (fetch_if.redirect) begin
      // Word in flight is the wrong path
      pc_r <= fetch_if.redirect_pc;
      inst_v_r <= 1'b0;
    end else if (!fetch_if.stall) begin
      inst_pc_r <= pc_r;
      pc_r <= pc_r + 1'b1;
      inst_v_r <= 1'b1;
    end
  end

  assign fetch_if.pc = inst_pc_r;
  assign fetch_if.inst = cce_inst_pkg::cce_inst_s'(ram_q);
  assign fetch_if.inst_v = inst_v_r && cce_mode_i;
  assign ucode_data_o = ram_q;

  // A restart begins with one bubble, then the word at PC 0
  a_restart_pc0: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(cce_mode_i) |-> !fetch_if.inst_v ##1 (fetch_if.inst_v && fetch_if.pc == '0));

endmodule

// ==== design/cce_exec.sv ====
module cce_exec (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  cce_fetch_if.exec                       fetch_if,
  input  logic                            req_v_i,
  input  logic [cce_pkg::paddr_width-1:0] req_addr_i,
  output logic                            req_pop_o,
  cce_cmd_if.source                       cmd_if
);

  cce_inst_pkg::cce_inst_s inst;

  logic [cce_pkg::num_gpr-1:0][cce_pkg::gpr_width-1:0] gpr_r;

  logic [cce_pkg::gpr_width-1:0] src_a;
  logic [cce_pkg::gpr_width-1:0] src_b;
  logic [cce_pkg::gpr_width-1:0] alu_res;
  logic                          gpr_we;
  logic                          is_pop;
  logic                          is_push;
  logic                          taken;
  logic                          stall;

  assign inst = fetch_if.inst;
  assign src_a = gpr_r[inst.ra];
  assign src_b = gpr_r[inst.rb];

  // Decode and ALU
  always_comb begin
    alu_res = '0;
    gpr_we = 1'b0;
    is_pop = 1'b0;
    is_push = 1'b0;
    taken = 1'b0;
    case (inst.op)
      cce_inst_pkg::e_movi: begin
        alu_res = inst.imm;
        gpr_we = 1'b1;
      end
      cce_inst_pkg::e_add: begin
        alu_res = src_a + src_b;
        gpr_we = 1'b1;
      end
      cce_inst_pkg::e_sub: begin
        alu_res = src_a - src_b;
        gpr_we = 1'b1;
      end
      cce_inst_pkg::e_addi: begin
        alu_res = src_a + inst.imm;
        gpr_we = 1'b1;
      end
      cce_inst_pkg::e_beq: taken = (src_a == src_b);
      cce_inst_pkg::e_bne: taken = (src_a != src_b);
      cce_inst_pkg::e_jmp: taken = 1'b1;
      cce_inst_pkg::e_popq: begin
        alu_res = req_addr_i;
        gpr_we = 1'b1;
        is_pop = 1'b1;
      end
      cce_inst_pkg::e_pushq: is_push = 1'b1;
      default: alu_res = '0;
    endcase
  end

  // Wait on an empty request buffer or a full command register
  assign stall = fetch_if.inst_v && ((is_pop && !req_v_i) || (is_push && !cmd_if.ready));
  assign fetch_if.stall = stall;

  // Branches resolve here, fetch has already moved on to pc+1
  assign fetch_if.redirect = fetch_if.inst_v && taken;
  assign fetch_if.redirect_pc = inst.imm[cce_pkg::pc_width-1:0];

  assign req_pop_o = fetch_if.inst_v && is_pop && !stall;

  assign cmd_if.v = fetch_if.inst_v && is_push;
  assign cmd_if.addr = src_a;
  assign cmd_if.op = cce_pkg::cce_mem_op_e'(inst.imm[0]);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpr_r <= '0;
    end else if (fetch_if.inst_v && gpr_we && !stall) begin
      gpr_r[inst.rd] <= alu_res;
    end
  end

  // One bubble after a taken branch, then the target word
  a_redirect_target: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    fetch_if.redirect |=> !fetch_if.inst_v ##1
      (!fetch_if.inst_v || fetch_if.pc == $past(fetch_if.redirect_pc, 2)));

endmodule

// ==== design/cce_cmd_out.sv ====
module cce_cmd_out (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  cce_cmd_if.sink                         cmd_if,
  output logic [cce_pkg::paddr_width-1:0] mem_cmd_addr_o,
  output cce_pkg::cce_mem_op_e            mem_cmd_op_o,
  output logic                            mem_cmd_v_o,
  input  logic                            mem_cmd_ready_i
);

  logic                            full_r;
  logic [cce_pkg::paddr_width-1:0] addr_r;
  cce_pkg::cce_mem_op_e            op_r;

  // Room when empty or when the held command leaves this cycle
  assign cmd_if.ready = !full_r || mem_cmd_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      full_r <= 1'b0;
    end else if (cmd_if.v && cmd_if.ready) begin
      full_r <= 1'b1;
    end else if (mem_cmd_ready_i) begin
      full_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_if.v && cmd_if.ready) begin
      addr_r <= cmd_if.addr;
      op_r <= cmd_if.op;
    end
  end

  assign mem_cmd_v_o = full_r;
  assign mem_cmd_addr_o = addr_r;
  assign mem_cmd_op_o = op_r;

  // A waiting command is neither dropped nor replaced
  a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mem_cmd_v_o && !mem_cmd_ready_i |=>
      mem_cmd_v_o && $stable(mem_cmd_addr_o) && $stable(mem_cmd_op_o));

endmodule

// ==== design/cce_top.sv ====
module cce_top (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 cce_mode_i,

  // Microcode programming port
  input  logic                                 ucode_v_i,
  input  logic                                 ucode_w_i,
  input  logic [cce_pkg::pc_width-1:0]         ucode_addr_i,
  input  logic [cce_inst_pkg::inst_width-1:0]  ucode_data_i,
  output logic [cce_inst_pkg::inst_width-1:0]  ucode_data_o,

  // LCE request, valid/yumi
  input  logic [cce_pkg::paddr_width-1:0]      lce_req_addr_i,
  input  logic                                 lce_req_v_i,
  output logic                                 lce_req_yumi_o,

  // Memory command, valid/ready
  output logic [cce_pkg::paddr_width-1:0]      mem_cmd_addr_o,
  output cce_pkg::cce_mem_op_e                 mem_cmd_op_o,
  output logic                                 mem_cmd_v_o,
  input  logic                                 mem_cmd_ready_i
);

  logic                            req_v;
  logic [cce_pkg::paddr_width-1:0] req_addr;
  logic                            req_pop;

  cce_fetch_if fetch_if ();
  cce_cmd_if   cmd_if ();

  cce_req_in req_in (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .lce_req_addr_i (lce_req_addr_i),
    .lce_req_v_i    (lce_req_v_i),
    .lce_req_yumi_o (lce_req_yumi_o),
    .req_v_o        (req_v),
    .req_addr_o     (req_addr),
    .req_pop_i      (req_pop)
  );

  cce_fetch fetch (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .cce_mode_i   (cce_mode_i),
    .ucode_v_i    (ucode_v_i),
    .ucode_w_i    (ucode_w_i),
    .ucode_addr_i (ucode_addr_i),
    .ucode_data_i (ucode_data_i),
    .ucode_data_o (ucode_data_o),
    .fetch_if     (fetch_if.fetch)
  );

  cce_exec exec (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .fetch_if   (fetch_if.exec),
    .req_v_i    (req_v),
    .req_addr_i (req_addr),
    .req_pop_o  (req_pop),
    .cmd_if     (cmd_if.source)
  );

  cce_cmd_out cmd_out (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .cmd_if          (cmd_if.sink),
    .mem_cmd_addr_o  (mem_cmd_addr_o),
    .mem_cmd_op_o    (mem_cmd_op_o),
    .mem_cmd_v_o     (mem_cmd_v_o),
    .mem_cmd_ready_i (mem_cmd_ready_i)
  );

endmodule

// ==== verif/cce_tb.sv ====
module cce_tb;

  logic                                clk_i = 1'b0;
  logic                                rst_n_i;
  logic                                cce_mode_i;
  logic                                ucode_v_i;
  logic                                ucode_w_i;
  logic [cce_pkg::pc_width-1:0]        ucode_addr_i;
  logic [cce_inst_pkg::inst_width-1:0] ucode_data_i;
  logic [cce_inst_pkg::inst_width-1:0] ucode_data_o;
  logic [cce_pkg::paddr_width-1:0]     lce_req_addr_i;
  logic                                lce_req_v_i;
  logic                                lce_req_yumi_o;
  logic [cce_pkg::paddr_width-1:0]     mem_cmd_addr_o;
  cce_pkg::cce_mem_op_e                mem_cmd_op_o;
  logic                                mem_cmd_v_o;
  logic                                mem_cmd_ready_i;

  integer      seed = 74647;
  integer      errors = 0;
  integer      cmds_checked = 0;
  integer      cycles = 0;
  integer      cycle_limit = 64;
  integer      yumi_count = 0;
  integer      ready_low = 0;
  logic        ready_random = 1'b0;
  logic        hold_v = 1'b0;
  logic [16:0] hold_cmd;
  string       test_name = "reset";

  // Program image, request stream and expected {op, addr} commands
  logic [cce_inst_pkg::inst_width-1:0] prog [cce_pkg::ucode_depth];
  logic [15:0]                         reqs [$];
  logic [16:0]                         exp_q [$];

  cce_top uut (.*);

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles in test %s", cycles, test_name);
      $display("Testbench failed");
      $finish;
    end
  end

  // Random ready, never low for more than three cycles in a row
  always @(posedge clk_i) begin
    #1;
    mem_cmd_ready_i = !ready_random || (ready_low >= 3) || ($random(seed) % 2 == 0);
    ready_low = mem_cmd_ready_i ? 0 : ready_low + 1;
  end

  // Sample mid-cycle, a transfer completes on the next rising edge
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      if (hold_v && !mem_cmd_v_o) begin
        $display("Waiting memory command was dropped in test %s", test_name);
        errors++;
      end else if (hold_v && {mem_cmd_op_o, mem_cmd_addr_o} != hold_cmd) begin
        $display("[FAIL] %s hold: expected %h actual %h", test_name, hold_cmd,
                 {mem_cmd_op_o, mem_cmd_addr_o});
        errors++;
      end
      hold_v = mem_cmd_v_o && !mem_cmd_ready_i;
      hold_cmd = {mem_cmd_op_o, mem_cmd_addr_o};
      if (mem_cmd_v_o && mem_cmd_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("Unexpected extra memory command in test %s", test_name);
          errors++;
        end else begin
          if ({mem_cmd_op_o, mem_cmd_addr_o} != exp_q[0]) begin
            $display("[FAIL] %s cmd: expected %h actual %h", test_name, exp_q[0],
                     {mem_cmd_op_o, mem_cmd_addr_o});
            errors++;
          end
          void'(exp_q.pop_front());
          cmds_checked++;
        end
      end
      if (lce_req_yumi_o) begin
        yumi_count++;
        if (!lce_req_v_i) begin
          $display("Request accepted without valid in test %s", test_name);
          errors++;
        end
      end
    end
  end

  task automatic tick(input int n);
    repeat (n) @(posedge clk_i);
    #1;
  endtask

  function automatic logic [15:0] rand16();
    logic [31:0] r;
    r = $random(seed);
    return r[15:0];
  endfunction

  function automatic logic [25:0] make_inst(input cce_inst_pkg::cce_opcode_e op,
                                            input int rd, input int ra, input int rb,
                                            input logic [15:0] imm);
    return {op, rd[1:0], ra[1:0], rb[1:0], imm};
  endfunction

  task automatic apply_reset();
    rst_n_i = 1'b0;
    cce_mode_i = 1'b0;
    ucode_v_i = 1'b0;
    lce_req_v_i = 1'b0;
    hold_v = 1'b0;
    tick(2);
    rst_n_i = 1'b1;
    tick(1);
  endtask

  task automatic load_program(input int n);
    for (int i = 0; i < n; i++) begin
      ucode_v_i = 1'b1;
      ucode_w_i = 1'b1;
      ucode_addr_i = i[7:0];
      ucode_data_i = prog[i];
      tick(1);
    end
    ucode_v_i = 1'b0;
  endtask

  // Microcode interpreter, stops on a jump to itself or a pop with no request left
  task automatic run_model(output int steps);
    logic [15:0] r [4];
    logic [7:0]  pc;
    logic [7:0]  pc_next;
    logic [25:0] w;
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] imm;
    int          req_idx;
    bit          done;
    for (int i = 0; i < 4; i++) r[i] = 16'h0;
    pc = 8'd0;
    req_idx = 0;
    steps = 0;
    done = 1'b0;
    while (!done && steps < 2000) begin
      w = prog[pc];
      a = r[w[19:18]];
      b = r[w[17:16]];
      imm = w[15:0];
      pc_next = pc + 8'd1;
      steps++;
      case (w[25:22])
        cce_inst_pkg::e_movi: r[w[21:20]] = imm;
        cce_inst_pkg::e_add:  r[w[21:20]] = a + b;
        cce_inst_pkg::e_sub:  r[w[21:20]] = a - b;
        cce_inst_pkg::e_addi: r[w[21:20]] = a + imm;
        cce_inst_pkg::e_beq:  if (a == b) pc_next = imm[7:0];
        cce_inst_pkg::e_bne:  if (a != b) pc_next = imm[7:0];
        cce_inst_pkg::e_jmp: begin
          done = (imm[7:0] == pc);
          pc_next = imm[7:0];
        end
        cce_inst_pkg::e_popq: begin
          if (req_idx < reqs.size()) begin
            r[w[21:20]] = reqs[req_idx];
            req_idx++;
          end else begin
            done = 1'b1;
          end
        end
        cce_inst_pkg::e_pushq: exp_q.push_back({imm[0], a});
        default: ;
      endcase
      pc = pc_next;
    end
  endtask

  task automatic send_requests(input int max_gap);
    int gap;
    bit taken;
    foreach (reqs[i]) begin
      gap = $unsigned($random(seed)) % (max_gap + 1);
      repeat (gap) tick(1);
      lce_req_v_i = 1'b1;
      lce_req_addr_i = reqs[i];
      taken = 1'b0;
      while (!taken) begin
        @(negedge clk_i);
        taken = lce_req_yumi_o;
        tick(1);
      end
      lce_req_v_i = 1'b0;
    end
  endtask

  task automatic run_program(input string name, input int n_prog, input int max_gap,
                             input bit rnd_ready);
    int steps;
    test_name = name;
    cycle_limit = cycles + n_prog + 16;
    apply_reset();
    load_program(n_prog);
    exp_q.delete();
    run_model(steps);
    cycle_limit = cycles + 3 * steps + reqs.size() * (max_gap + 4) + exp_q.size() * 5 + 64;
    ready_random = rnd_ready;
    yumi_count = 0;
    cce_mode_i = 1'b1;
    send_requests(max_gap);
    while (exp_q.size() > 0) tick(1);
    // Parked program must stay quiet
    tick(10);
    if (yumi_count != reqs.size()) begin
      $display("[FAIL] %s yumi count: expected %0d actual %0d", name, reqs.size(), yumi_count);
      errors++;
    end
    cce_mode_i = 1'b0;
    ready_random = 1'b0;
  endtask

  initial begin
    rst_n_i = 1'b0;
    cce_mode_i = 1'b0;
    ucode_v_i = 1'b0;
    ucode_w_i = 1'b0;
    ucode_addr_i = '0;
    ucode_data_i = '0;
    lce_req_addr_i = '0;
    lce_req_v_i = 1'b0;
    mem_cmd_ready_i = 1'b1;

    test_name = "ucode_rw";
    cycle_limit = 2 * cce_pkg::ucode_depth + 32;
    apply_reset();
    if (mem_cmd_v_o || lce_req_yumi_o) begin
      $display("Valid outputs not low after reset");
      errors++;
    end
    for (int i = 0; i < cce_pkg::ucode_depth; i++) prog[i] = $random(seed);
    load_program(cce_pkg::ucode_depth);
    for (int i = 0; i < cce_pkg::ucode_depth; i++) begin
      ucode_v_i = 1'b1;
      ucode_w_i = 1'b0;
      ucode_addr_i = i[7:0];
      tick(1);
      if (ucode_data_o != prog[i]) begin
        $display("[FAIL] %s addr %0d: expected %h actual %h", test_name, i, prog[i],
                 ucode_data_o);
        errors++;
      end
    end
    ucode_v_i = 1'b0;

    reqs.delete();
    prog[0] = make_inst(cce_inst_pkg::e_movi, 0, 0, 0, rand16());
    prog[1] = make_inst(cce_inst_pkg::e_movi, 1, 0, 0, rand16());
    prog[2] = make_inst(cce_inst_pkg::e_add, 2, 0, 1, 16'h0);
    prog[3] = make_inst(cce_inst_pkg::e_pushq, 0, 2, 0, rand16());
    prog[4] = make_inst(cce_inst_pkg::e_sub, 3, 0, 1, 16'h0);
    prog[5] = make_inst(cce_inst_pkg::e_pushq, 0, 3, 0, rand16());
    prog[6] = make_inst(cce_inst_pkg::e_addi, 0, 2, 0, rand16());
    prog[7] = make_inst(cce_inst_pkg::e_pushq, 0, 0, 0, rand16());
    prog[8] = make_inst(cce_inst_pkg::e_sub, 1, 1, 3, 16'h0);
    prog[9] = make_inst(cce_inst_pkg::e_pushq, 0, 1, 0, rand16());
    prog[10] = make_inst(cce_inst_pkg::e_jmp, 0, 0, 0, 16'd10);
    run_program("arith", 11, 0, 1'b0);

    // Count-down loop, words after taken branches must be squashed
    prog[0] = make_inst(cce_inst_pkg::e_movi, 0, 0, 0, (rand16() % 6) + 1);
    prog[1] = make_inst(cce_inst_pkg::e_movi, 1, 0, 0, 16'h0);
    prog[2] = make_inst(cce_inst_pkg::e_movi, 2, 0, 0, rand16());
    prog[3] = make_inst(cce_inst_pkg::e_beq, 0, 1, 1, 16'd5);
    prog[4] = make_inst(cce_inst_pkg::e_pushq, 0, 1, 0, 16'h1);
    prog[5] = make_inst(cce_inst_pkg::e_add, 3, 3, 2, 16'h0);
    prog[6] = make_inst(cce_inst_pkg::e_pushq, 0, 3, 0, rand16());
    prog[7] = make_inst(cce_inst_pkg::e_addi, 0, 0, 0, 16'hffff);
    prog[8] = make_inst(cce_inst_pkg::e_bne, 0, 0, 1, 16'd5);
    prog[9] = make_inst(cce_inst_pkg::e_addi, 3, 3, 0, 16'h0100);
    prog[10] = make_inst(cce_inst_pkg::e_pushq, 0, 3, 0, rand16());
    prog[11] = make_inst(cce_inst_pkg::e_jmp, 0, 0, 0, 16'd11);
    prog[12] = make_inst(cce_inst_pkg::e_pushq, 0, 2, 0, 16'h1);
    run_program("branch", 13, 0, 1'b0);

    repeat (12) reqs.push_back(rand16());
    prog[0] = make_inst(cce_inst_pkg::e_popq, 0, 0, 0, 16'h0);
    prog[1] = make_inst(cce_inst_pkg::e_pushq, 0, 0, 0, rand16());
    prog[2] = make_inst(cce_inst_pkg::e_jmp, 0, 0, 0, 16'd0);
    run_program("forward", 3, 4, 1'b0);

    reqs.delete();
    repeat (16) reqs.push_back(rand16());
    prog[0] = make_inst(cce_inst_pkg::e_popq, 0, 0, 0, 16'h0);
    prog[1] = make_inst(cce_inst_pkg::e_pushq, 0, 0, 0, 16'h0);
    prog[2] = make_inst(cce_inst_pkg::e_addi, 1, 0, 0, 16'h1);
    prog[3] = make_inst(cce_inst_pkg::e_pushq, 0, 1, 0, 16'h1);
    prog[4] = make_inst(cce_inst_pkg::e_jmp, 0, 0, 0, 16'd0);
    run_program("backpressure", 5, 2, 1'b1);

    $display("Commands checked: %0d, errors: %0d", cmds_checked, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== project.f ====
common/cce_pkg.sv
common/cce_inst_pkg.sv
common/cce_ifs.sv
design/cce_req_in.sv
design/cce_fetch.sv
design/cce_exec.sv
design/cce_cmd_out.sv
design/cce_top.sv
verif/cce_tb.sv

// ==== Bender.yml ====
package:
  name: cce

sources:
  - common/cce_pkg.sv
  - common/cce_inst_pkg.sv
  - common/cce_ifs.sv
  - design/cce_req_in.sv
  - design/cce_fetch.sv
  - design/cce_exec.sv
  - design/cce_cmd_out.sv
  - design/cce_top.sv
  - target: simulation
    files:
      - verif/cce_tb.sv
